// File: logic/bridgePkg.sv
`default_nettype none

package bridgePkg;

    // Bus widths
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int ID_WIDTH   = 4;
    localparam int LEN_WIDTH  = 4;

    // One entry per beat of the longest burst
    localparam int BUF_DEPTH  = 16;

    // AXI burst codes, WRAP runs as INCR
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } axiBurstT;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axiRespT;

    typedef enum logic [1:0] {
        TRANS_IDLE   = 2'b00,
        TRANS_NONSEQ = 2'b10
    } ahbTransT;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WR_COLLECT,
        ST_WR_AHB,
        ST_WR_RESP,
        ST_RD_AHB,
        ST_RD_STREAM
    } ctrlStateT;

endpackage

`default_nettype wire

// File: logic/bridgeIfs.sv
`default_nettype none

// Beat store access, one write port and one read port
interface bufIf #(
    parameter int width = bridgePkg::DATA_WIDTH
);
    import bridgePkg::*;

    logic                         wrEn;
    logic [$clog2(BUF_DEPTH)-1:0] wrAddr;
    logic [width-1:0]             wrData;
    logic [$clog2(BUF_DEPTH)-1:0] rdAddr;
    logic [width-1:0]             rdData;

    modport writer (
        output wrEn,
        output wrAddr,
        output wrData
    );

    modport reader (
        output rdAddr,
        input  rdData
    );

    // Seen from the buffer itself
    modport storage (
        input  wrEn,
        input  wrAddr,
        input  wrData,
        input  rdAddr,
        output rdData
    );
endinterface

// Transfer command from the AXI side to the AHB engine
interface xferIf;
    import bridgePkg::*;

    logic                  start;
    logic                  write;
    logic [ADDR_WIDTH-1:0] addr;
    logic [2:0]            size;
    axiBurstT              burst;
    logic [LEN_WIDTH-1:0]  len;
    logic                  done;
    logic                  error;

    modport ctrl (
        output start, write, addr, size, burst, len,
        input  done, error
    );

    modport engine (
        input  start, write, addr, size, burst, len,
        output done, error
    );
endinterface

`default_nettype wire

// File: logic/beatBuffer.sv
`default_nettype none

module beatBuffer #(
    parameter int width = bridgePkg::DATA_WIDTH
) (
    input  wire   ACLK,
    input  wire   arstN,
    bufIf.storage port
);
    import bridgePkg::*;

    logic [width-1:0] mem [BUF_DEPTH];

    // Write on the clock edge
    always_ff @(posedge ACLK or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int i = 0; i < BUF_DEPTH; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (port.wrEn)
        begin
            mem[port.wrAddr] <= port.wrData;
        end
    end

    // Read data follows the address in the same cycle
    assign port.rdData = mem[port.rdAddr];

endmodule

`default_nettype wire

// File: logic/axiSlaveCtrl.sv
`default_nettype none

module axiSlaveCtrl (
    input  wire                              ACLK,
    input  wire                              arstN,
    // Write address
    input  wire                              awValid,
    input  wire [bridgePkg::ADDR_WIDTH-1:0]  awAddr,
    input  wire [bridgePkg::LEN_WIDTH-1:0]   awLen,
    input  wire [2:0]                        awSize,
    input  wire [1:0]                        awBurst,
    input  wire [bridgePkg::ID_WIDTH-1:0]    awId,
    output logic                             awReady,
    // Write data
    input  wire                              wValid,
    input  wire [bridgePkg::DATA_WIDTH-1:0]  wData,
    input  wire                              wLast,
    output logic                             wReady,
    // Write response
    output logic                             bValid,
    input  wire                              bReady,
    output bridgePkg::axiRespT               bResp,
    output logic [bridgePkg::ID_WIDTH-1:0]   bId,
    // Read address
    input  wire                              arValid,
    input  wire [bridgePkg::ADDR_WIDTH-1:0]  arAddr,
    input  wire [bridgePkg::LEN_WIDTH-1:0]   arLen,
    input  wire [2:0]                        arSize,
    input  wire [1:0]                        arBurst,
    input  wire [bridgePkg::ID_WIDTH-1:0]    arId,
    output logic                             arReady,
    // Read data
    output logic                             rValid,
    input  wire                              rReady,
    output logic [bridgePkg::DATA_WIDTH-1:0] rData,
    output bridgePkg::axiRespT               rResp,
    output logic                             rLast,
    output logic [bridgePkg::ID_WIDTH-1:0]   rId,
    // Buffers and engine
    bufIf.writer                             wrBuf,
    bufIf.reader                             rdBuf,
    xferIf.ctrl                              xfer
);
    import bridgePkg::*;

    ctrlStateT             state;
    logic [ADDR_WIDTH-1:0] cmdAddr;
    logic [LEN_WIDTH-1:0]  cmdLen;
    logic [2:0]            cmdSize;
    axiBurstT              cmdBurst;
    logic [ID_WIDTH-1:0]   cmdId;
    logic [LEN_WIDTH-1:0]  beatCnt;

    logic awHs;
    logic wHs;
    logic arHs;
    logic rHs;
    logic wFinal;
    logic rdLoad;

    ////////////////////////////////////////////////////////////
    // Handshakes
    ////////////////////////////////////////////////////////////
    assign awReady = (state == ST_IDLE);
    // Write wins when both channels are waiting
    assign arReady = (state == ST_IDLE) && !awValid;
    assign wReady  = (state == ST_WR_COLLECT);

    assign awHs   = awValid && awReady;
    assign wHs    = wValid && wReady;
    assign arHs   = arValid && arReady;
    assign rHs    = rValid && rReady;
    assign wFinal = wLast || (beatCnt == cmdLen);

    // Next read beat taken from the buffer
    assign rdLoad = ((state == ST_RD_AHB) && xfer.done)
                  || ((state == ST_RD_STREAM) && rHs && !rLast);

    assign wrBuf.wrEn   = wHs;
    assign wrBuf.wrAddr = beatCnt;
    assign wrBuf.wrData = wData;
    assign rdBuf.rdAddr = beatCnt;

    ////////////////////////////////////////////////////////////
    // Engine command
    ////////////////////////////////////////////////////////////
    // In IDLE the AR fields go straight through so the read starts at once
    assign xfer.start = (wHs && wFinal) || arHs;
    assign xfer.write = (state == ST_WR_COLLECT) || (state == ST_WR_AHB);
    assign xfer.addr  = (state == ST_IDLE) ? arAddr : cmdAddr;
    assign xfer.size  = (state == ST_IDLE) ? arSize : cmdSize;
    assign xfer.burst = (state == ST_IDLE) ? axiBurstT'(arBurst) : cmdBurst;
    assign xfer.len   = (state == ST_IDLE) ? arLen : cmdLen;

    assign bId = cmdId;
    assign rId = cmdId;

    ////////////////////////////////////////////////////////////
    // Transaction FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge ACLK or negedge arstN)
    begin
        if (!arstN)
        begin
            state    <= ST_IDLE;
            cmdAddr  <= '0;
            cmdLen   <= '0;
            cmdSize  <= '0;
            cmdBurst <= BURST_FIXED;
            cmdId    <= '0;
            beatCnt  <= '0;
            bValid   <= 1'b0;
            bResp    <= RESP_OKAY;
            rValid   <= 1'b0;
            rResp    <= RESP_OKAY;
            rLast    <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    beatCnt <= '0;
                    if (awHs)
                    begin
                        cmdAddr  <= awAddr;
                        cmdLen   <= awLen;
                        cmdSize  <= awSize;
                        cmdBurst <= axiBurstT'(awBurst);
                        cmdId    <= awId;
                        state    <= ST_WR_COLLECT;
                    end
                    else if (arHs)
                    begin
                        cmdAddr  <= arAddr;
                        cmdLen   <= arLen;
                        cmdSize  <= arSize;
                        cmdBurst <= axiBurstT'(arBurst);
                        cmdId    <= arId;
                        state    <= ST_RD_AHB;
                    end
                end
                ST_WR_COLLECT:
                begin
                    if (wHs)
                    begin
                        beatCnt <= beatCnt + 1'b1;
                        if (wFinal)
                        begin
                            state <= ST_WR_AHB;
                        end
                    end
                end
                ST_WR_AHB:
                begin
                    if (xfer.done)
                    begin
                        bValid <= 1'b1;
                        bResp  <= xfer.error ? RESP_SLVERR : RESP_OKAY;
                        state  <= ST_WR_RESP;
                    end
                end
                ST_WR_RESP:
                begin
                    if (bReady)
                    begin
                        bValid <= 1'b0;
                        state  <= ST_IDLE;
                    end
                end
                ST_RD_AHB:
                begin
                    if (xfer.done)
                    begin
                        rValid <= 1'b1;
                        state  <= ST_RD_STREAM;
                    end
                end
                ST_RD_STREAM:
                begin
                    if (rHs && rLast)
                    begin
                        rValid <= 1'b0;
                        state  <= ST_IDLE;
                    end
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase

            if (rdLoad)
            begin
                // Stored error bit sits above the data
                rResp   <= rdBuf.rdData[DATA_WIDTH] ? RESP_SLVERR : RESP_OKAY;
                rLast   <= (beatCnt == cmdLen);
                beatCnt <= beatCnt + 1'b1;
            end
        end
    end

    always_ff @(posedge ACLK)
    begin
        if (rdLoad)
        begin
            rData <= rdBuf.rdData[DATA_WIDTH-1:0];
        end
    end

endmodule

`default_nettype wire

// File: logic/ahbBeatEngine.sv
`default_nettype none

module ahbBeatEngine (
    input  wire                              ACLK,
    input  wire                              arstN,
    xferIf.engine                            xfer,
    bufIf.reader                             wrBuf,
    bufIf.writer                             rdBuf,
    output logic [bridgePkg::ADDR_WIDTH-1:0] hAddr,
    output bridgePkg::ahbTransT              hTrans,
    output logic                             hWrite,
    output logic [2:0]                       hSize,
    output logic [2:0]                       hBurst,
    output logic [bridgePkg::DATA_WIDTH-1:0] hWData,
    input  wire  [bridgePkg::DATA_WIDTH-1:0] hRData,
    input  wire                              hReady,
    input  wire                              hResp
);
    import bridgePkg::*;

    // Address phase and data phase state
    logic                  aActive;
    logic                  dActive;
    logic [LEN_WIDTH-1:0]  aCnt;
    logic [LEN_WIDTH-1:0]  dCnt;
    logic                  errAcc;
    logic                  lastData;
    logic [ADDR_WIDTH-1:0] addrStep;

    ////////////////////////////////////////////////////////////
    // AHB outputs
    ////////////////////////////////////////////////////////////
    assign hTrans = aActive ? TRANS_NONSEQ : TRANS_IDLE;
    assign hWrite = xfer.write;
    assign hSize  = xfer.size;
    // SINGLE, every beat is its own NONSEQ transfer
    assign hBurst = 3'b000;

    // Write data comes from the beat in its data phase
    assign wrBuf.rdAddr = dCnt;
    assign hWData       = wrBuf.rdData;

    // Read beat stored with its response bit
    assign rdBuf.wrEn   = dActive && hReady && !xfer.write;
    assign rdBuf.wrAddr = dCnt;
    assign rdBuf.wrData = {hResp, hRData};

    assign lastData = dActive && hReady && (dCnt == xfer.len);
    assign addrStep = (xfer.burst == BURST_FIXED) ? '0 : (ADDR_WIDTH'(1) << xfer.size);

    ////////////////////////////////////////////////////////////
    // Beat pipeline
    ////////////////////////////////////////////////////////////
    always_ff @(posedge ACLK or negedge arstN)
    begin
        if (!arstN)
        begin
            aActive    <= 1'b0;
            dActive    <= 1'b0;
            aCnt       <= '0;
            dCnt       <= '0;
            hAddr      <= '0;
            errAcc     <= 1'b0;
            xfer.done  <= 1'b0;
            xfer.error <= 1'b0;
        end
        else
        begin
            xfer.done <= lastData;
            if (lastData)
            begin
                xfer.error <= errAcc | hResp;
            end

            if (xfer.start)
            begin
                aActive <= 1'b1;
                aCnt    <= '0;
                hAddr   <= xfer.addr;
                errAcc  <= 1'b0;
            end
            else if (hReady)
            begin
                // Current address phase becomes the data phase
                dActive <= aActive;
                dCnt    <= aCnt;
                if (dActive)
                begin
                    errAcc <= errAcc | hResp;
                end
                if (aActive)
                begin
                    if (aCnt == xfer.len)
                    begin
                        aActive <= 1'b0;
                    end
                    else
                    begin
                        aCnt  <= aCnt + 1'b1;
                        hAddr <= hAddr + addrStep;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/axiAhbBridge.sv
`default_nettype none

module axiAhbBridge (
    input  wire                              ACLK,
    input  wire                              arstN,
    // AXI write address
    input  wire                              awValid,
    input  wire [bridgePkg::ADDR_WIDTH-1:0]  awAddr,
    input  wire [bridgePkg::LEN_WIDTH-1:0]   awLen,
    input  wire [2:0]                        awSize,
    input  wire [1:0]                        awBurst,
    input  wire [bridgePkg::ID_WIDTH-1:0]    awId,
    output logic                             awReady,
    // AXI write data and response
    input  wire                              wValid,
    input  wire [bridgePkg::DATA_WIDTH-1:0]  wData,
    input  wire                              wLast,
    output logic                             wReady,
    output logic                             bValid,
    input  wire                              bReady,
    output bridgePkg::axiRespT               bResp,
    output logic [bridgePkg::ID_WIDTH-1:0]   bId,
    // AXI read address
    input  wire                              arValid,
    input  wire [bridgePkg::ADDR_WIDTH-1:0]  arAddr,
    input  wire [bridgePkg::LEN_WIDTH-1:0]   arLen,
    input  wire [2:0]                        arSize,
    input  wire [1:0]                        arBurst,
    input  wire [bridgePkg::ID_WIDTH-1:0]    arId,
    output logic                             arReady,
    // AXI read data
    output logic                             rValid,
    input  wire                              rReady,
    output logic [bridgePkg::DATA_WIDTH-1:0] rData,
    output bridgePkg::axiRespT               rResp,
    output logic                             rLast,
    output logic [bridgePkg::ID_WIDTH-1:0]   rId,
    // AHB-Lite master
    output logic [bridgePkg::ADDR_WIDTH-1:0] hAddr,
    output bridgePkg::ahbTransT              hTrans,
    output logic                             hWrite,
    output logic [2:0]                       hSize,
    output logic [2:0]                       hBurst,
    output logic [bridgePkg::DATA_WIDTH-1:0] hWData,
    input  wire  [bridgePkg::DATA_WIDTH-1:0] hRData,
    input  wire                              hReady,
    input  wire                              hResp
);
    import bridgePkg::*;

    // Read entries carry the AHB error bit on top
    bufIf #(.width(DATA_WIDTH))     wrBufBus ();
    bufIf #(.width(DATA_WIDTH + 1)) rdBufBus ();
    xferIf                          xferBus ();

    axiSlaveCtrl ctrl (
        .*,
        .wrBuf (wrBufBus.writer),
        .rdBuf (rdBufBus.reader),
        .xfer  (xferBus.ctrl)
    );

    ahbBeatEngine engine (
        .*,
        .xfer  (xferBus.engine),
        .wrBuf (wrBufBus.reader),
        .rdBuf (rdBufBus.writer)
    );

    beatBuffer #(.width(DATA_WIDTH)) wrBuffer (
        .ACLK  (ACLK),
        .arstN (arstN),
        .port  (wrBufBus.storage)
    );

    beatBuffer #(.width(DATA_WIDTH + 1)) rdBuffer (
        .ACLK  (ACLK),
        .arstN (arstN),
        .port  (rdBufBus.storage)
    );

endmodule

`default_nettype wire

// File: tests/ahbMemModel.sv
`default_nettype none

module ahbMemModel (
    input  wire                              ACLK,
    input  wire                              arstN,
    input  wire [bridgePkg::ADDR_WIDTH-1:0]  hAddr,
    input  wire [1:0]                        hTrans,
    input  wire                              hWrite,
    input  wire [2:0]                        hSize,
    input  wire [bridgePkg::DATA_WIDTH-1:0]  hWData,
    output logic [bridgePkg::DATA_WIDTH-1:0] hRData,
    output logic                             hReady,
    output logic                             hResp
);
    timeunit 1ns;
    timeprecision 1ps;
    import bridgePkg::*;

    // 64 KiB of bytes, starts out all zero
    bit [7:0]    mem [65536];
    logic        dValid;
    logic        dWrite;
    logic        dErr;
    logic [15:0] dAddr;
    logic [2:0]  dSize;

    // Upper half of the space is the error region
    assign hResp  = dValid && dErr;
    assign hRData = {mem[{dAddr[15:2], 2'd3}], mem[{dAddr[15:2], 2'd2}],
                     mem[{dAddr[15:2], 2'd1}], mem[{dAddr[15:2], 2'd0}]};

    always @(posedge ACLK or negedge arstN)
    begin : phase
        logic        nextValid;
        logic [15:0] b;
        if (!arstN)
        begin
            dValid <= 1'b0;
            dWrite <= 1'b0;
            dErr   <= 1'b0;
            dAddr  <= '0;
            dSize  <= '0;
            hReady <= 1'b1;
        end
        else
        begin
            nextValid = dValid;
            if (hReady)
            begin
                // Data phase ends, bytes go to their own lanes
                if (dValid && dWrite && !dErr)
                begin
                    for (int i = 0; i < (1 << dSize); i++)
                    begin
                        b = dAddr + 16'(i);
                        mem[b] <= hWData[8 * b[1:0] +: 8];
                    end
                end
                nextValid = (hTrans == TRANS_NONSEQ);
                dValid    <= nextValid;
                dAddr     <= hAddr[15:0];
                dWrite    <= hWrite;
                dSize     <= hSize;
                dErr      <= hAddr[15];
            end
            // Wait states only inside a data phase
            hReady <= nextValid ? ($urandom_range(0, 3) != 0) : 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: tests/bridge_asserts.sv
`default_nettype none

module bridgeAsserts (
    input wire                             ACLK,
    input wire                             arstN,
    input wire [bridgePkg::ADDR_WIDTH-1:0] hAddr,
    input wire [1:0]                       hTrans,
    input wire                             hReady,
    input wire                             bValid,
    input wire                             bReady,
    input wire                             rValid,
    input wire                             rReady,
    input wire [bridgePkg::DATA_WIDTH-1:0] rData,
    input wire                             awReady
);
    timeunit 1ns;
    timeprecision 1ps;
    import bridgePkg::*;

    // Address phase is held through slave wait states
    addrHeld: assert property (@(posedge ACLK) disable iff (!arstN)
        (hTrans == TRANS_NONSEQ) && !hReady |=> $stable(hAddr) && $stable(hTrans))
        else $error("AHB address or transfer type changed while hReady was low");

    bHeld: assert property (@(posedge ACLK) disable iff (!arstN)
        bValid && !bReady |=> bValid)
        else $error("bValid dropped before bReady");

    rHeld: assert property (@(posedge ACLK) disable iff (!arstN)
        rValid && !rReady |=> rValid && $stable(rData))
        else $error("Read beat changed or vanished before rReady");

    // No new write while a response is still pending
    awBlocked: assert property (@(posedge ACLK) disable iff (!arstN)
        bValid |-> !awReady)
        else $error("awReady was high while bValid was pending");

endmodule

bind axiAhbBridge bridgeAsserts protocolChecks (
    .ACLK    (ACLK),
    .arstN   (arstN),
    .hAddr   (hAddr),
    .hTrans  (hTrans),
    .hReady  (hReady),
    .bValid  (bValid),
    .bReady  (bReady),
    .rValid  (rValid),
    .rReady  (rReady),
    .rData   (rData),
    .awReady (awReady)
);

`default_nettype wire

// File: tests/tbAxiAhbBridge.sv
`default_nettype none

module tbAxiAhbBridge;
    timeunit 1ns;
    timeprecision 1ps;
    import bridgePkg::*;

    // About 50 bursts of up to 16 beats at some 25 cycles a beat with stalls
    localparam int TIMEOUT_CYCLES = 50 * 16 * 25;

    logic                  ACLK;
    logic                  arstN;
    logic                  awValid, awReady, wValid, wLast, wReady;
    logic                  bValid, bReady, arValid, arReady, rValid, rReady, rLast;
    logic                  hWrite, hReady, hResp;
    logic [ADDR_WIDTH-1:0] awAddr, arAddr, hAddr;
    logic [DATA_WIDTH-1:0] wData, rData, hWData, hRData;
    logic [LEN_WIDTH-1:0]  awLen, arLen;
    logic [ID_WIDTH-1:0]   awId, arId, bId, rId;
    logic [2:0]            awSize, arSize, hSize, hBurst;
    logic [1:0]            awBurst, arBurst;
    axiRespT               bResp, rResp;
    ahbTransT              hTrans;

    // Predicted contents of the AHB memory
    bit   [7:0]            shadow [65536];
    logic [DATA_WIDTH-1:0] burstData [BUF_DEPTH];
    int                    errorCount = 0;
    int                    checkCount = 0;
    int                    cycleCount = 0;

    axiAhbBridge uut (.*);
    ahbMemModel ahbMem (.*);

    initial ACLK = 1'b0;
    always #50 ACLK = ~ACLK;

    always @(posedge ACLK)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, a transfer never completed", cycleCount);
            $display("TEST FAIL");
            $finish;
        end
    end

    // Every beat goes out as a SINGLE transfer
    always @(negedge ACLK)
    begin
        if (arstN && (hTrans == TRANS_NONSEQ))
        begin
            checkValue("hBurst", 32'(hBurst), 32'h0);
        end
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////
    task automatic nextCycle();
        @(posedge ACLK);
        #10;
    endtask

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
        checkCount++;
        assert (got == expected)
        else
        begin
            errorCount++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    function automatic logic [31:0] beatAddr(input logic [31:0] base, input int beat,
                                             input logic [2:0] size, input logic [1:0] burst);
        if (burst == BURST_FIXED)
            return base;
        return base + (beat << size);
    endfunction

    task automatic shadowWrite(input logic [31:0] addr, input logic [2:0] size,
                               input logic [31:0] data);
        logic [31:0] a;
        for (int i = 0; i < (1 << size); i++)
        begin
            a = addr + i;
            // Error region keeps its contents
            if (!a[15])
                shadow[a[15:0]] = data[8 * a[1:0] +: 8];
        end
    endtask

    task automatic axiWrite(input logic [31:0] addr, input int len, input logic [2:0] size,
                            input logic [1:0] burst, input logic [3:0] id);
        bit          hs;
        bit          err;
        logic [31:0] a;
        err     = 1'b0;
        awValid = 1'b1;
        awAddr  = addr;
        awLen   = len[3:0];
        awSize  = size;
        awBurst = burst;
        awId    = id;
        do
        begin
            @(negedge ACLK);
            hs = awReady;
            nextCycle();
        end
        while (!hs);
        awValid = 1'b0;
        for (int k = 0; k <= len; k++)
        begin
            wValid = 1'b1;
            wData  = burstData[k];
            wLast  = (k == len);
            do
            begin
                @(negedge ACLK);
                hs = wReady;
                nextCycle();
            end
            while (!hs);
            a = beatAddr(addr, k, size, burst);
            err |= a[15];
            shadowWrite(a, size, burstData[k]);
        end
        wValid = 1'b0;
        wLast  = 1'b0;
        // Response taken with random back-pressure
        do
        begin
            bReady = ($urandom_range(0, 2) != 0);
            @(negedge ACLK);
            hs = bValid && bReady;
            if (hs)
            begin
                checkValue("bResp", 32'(bResp), err ? 32'(RESP_SLVERR) : 32'(RESP_OKAY));
                checkValue("bId", 32'(bId), 32'(id));
            end
            nextCycle();
        end
        while (!hs);
        bReady = 1'b0;
    endtask

    task automatic axiRead(input logic [31:0] addr, input int len, input logic [2:0] size,
                           input logic [1:0] burst, input logic [3:0] id, input bit throttle);
        bit          hs;
        bit          finished;
        int          beat;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] mask;
        logic [31:0] expData;
        arValid = 1'b1;
        arAddr  = addr;
        arLen   = len[3:0];
        arSize  = size;
        arBurst = burst;
        arId    = id;
        do
        begin
            @(negedge ACLK);
            hs = arReady;
            nextCycle();
        end
        while (!hs);
        arValid  = 1'b0;
        beat     = 0;
        finished = 1'b0;
        do
        begin
            rReady = throttle ? ($urandom_range(0, 2) != 0) : 1'b1;
            @(negedge ACLK);
            if (rValid && rReady)
            begin
                a       = beatAddr(addr, beat, size, burst);
                mask    = '0;
                expData = '0;
                // Only the active byte lanes carry data
                for (int i = 0; i < (1 << size); i++)
                begin
                    b = a + i;
                    mask[8 * b[1:0] +: 8]    = 8'hff;
                    expData[8 * b[1:0] +: 8] = shadow[b[15:0]];
                end
                checkValue("rResp", 32'(rResp), a[15] ? 32'(RESP_SLVERR) : 32'(RESP_OKAY));
                if (!a[15])
                    checkValue("rData", rData & mask, expData);
                checkValue("rId", 32'(rId), 32'(id));
                checkValue("rLast", 32'(rLast), 32'(beat == len));
                beat++;
                finished = rLast || (beat > len);
            end
            nextCycle();
        end
        while (!finished);
        rReady = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////
    task automatic singleWordTest();
        burstData[0] = 32'hcafe_f00d;
        axiWrite(32'h0000_0100, 0, 3'd2, BURST_INCR, 4'h3);
        axiRead(32'h0000_0100, 0, 3'd2, BURST_INCR, 4'h5, 1'b0);
    endtask

    task automatic incrBurstTest();
        for (int k = 0; k < BUF_DEPTH; k++)
            burstData[k] = $urandom();
        axiWrite(32'h0000_0200, 15, 3'd2, BURST_INCR, 4'h7);
        axiRead(32'h0000_0200, 15, 3'd2, BURST_INCR, 4'h8, 1'b1);
    endtask

    // Lane 3 byte written four times at one address
    task automatic fixedByteTest();
        for (int k = 0; k < 4; k++)
            burstData[k] = $urandom();
        axiWrite(32'h0000_0303, 3, 3'd0, BURST_FIXED, 4'h1);
        axiRead(32'h0000_0303, 3, 3'd0, BURST_FIXED, 4'h2, 1'b1);
    endtask

    // Beats 4 to 7 land above the 0x8000 boundary
    task automatic errorRegionTest();
        for (int k = 0; k < 8; k++)
            burstData[k] = $urandom();
        axiWrite(32'h0000_7ff0, 7, 3'd2, BURST_INCR, 4'h9);
        axiRead(32'h0000_7ff0, 7, 3'd2, BURST_INCR, 4'ha, 1'b1);
    endtask

    task automatic mixedTrafficTest();
        logic [2:0]  size;
        logic [1:0]  burst;
        logic [31:0] addr;
        int          len;
        for (int n = 0; n < 40; n++)
        begin
            size  = 3'($urandom_range(0, 2));
            burst = 2'($urandom_range(0, 1));
            len   = $urandom_range(0, 15);
            addr  = $urandom_range(0, 32'h3c0) & (32'hffff_ffff << size);
            for (int k = 0; k < BUF_DEPTH; k++)
                burstData[k] = $urandom();
            if ($urandom_range(0, 1) == 1)
                axiWrite(addr, len, size, burst, 4'($urandom()));
            else
                axiRead(addr, len, size, burst, 4'($urandom()), 1'b1);
        end
    endtask

    initial
    begin
        void'($urandom(32'he3be_aecd));
        arstN   = 1'b0;
        awValid = 1'b0;
        awAddr  = '0;
        awLen   = '0;
        awSize  = '0;
        awBurst = '0;
        awId    = '0;
        wValid  = 1'b0;
        wData   = '0;
        wLast   = 1'b0;
        bReady  = 1'b0;
        arValid = 1'b0;
        arAddr  = '0;
        arLen   = '0;
        arSize  = '0;
        arBurst = '0;
        arId    = '0;
        rReady  = 1'b0;
        repeat (5) @(posedge ACLK);
        #10;
        arstN = 1'b1;
        nextCycle();

        singleWordTest();
        incrBurstTest();
        fixedByteTest();
        errorRegionTest();
        mixedTrafficTest();

        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
logic/bridgePkg.sv
logic/bridgeIfs.sv
logic/beatBuffer.sv
logic/axiSlaveCtrl.sv
logic/ahbBeatEngine.sv
logic/axiAhbBridge.sv
tests/ahbMemModel.sv
tests/bridge_asserts.sv
tests/tbAxiAhbBridge.sv

// File: Makefile
SIM  := obj_dir/VtbAxiAhbBridge
SRCS := $(wildcard logic/*.sv tests/*.sv)

.PHONY: run clean

run: $(SIM)
	$(SIM) | tee sim.log
	grep -qx 'TEST PASS' sim.log

# Rebuilt only when a source or the file list changes
$(SIM): build.f $(SRCS)
	verilator --binary --assert --timescale 1ns/1ps \
		--top-module tbAxiAhbBridge -Mdir obj_dir -f build.f

clean:
	rm -rf obj_dir sim.log
